/* dsp_router.f */
source/dsp_pkg.sv
source/dsp_route_regs.sv
source/dsp_input_mux.sv
source/dsp_dac_mixer.sv
source/dsp_router.sv
test/dsp_router_props.sv
test/dsp_router_tb.sv

/* Makefile */
# verilator build, run and lint for the dsp router
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := dsp_router_tb
RTL_TOP    := dsp_router
FILELIST   := dsp_router.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/dsp_router_tb.sv */
// *********************************************************************
// dsp router testbench
// bus programming, crossbar, mixer, saturation and dac feedback checks
// *********************************************************************
`timescale 1ns/10ps
`default_nettype none

module dsp_router_tb
   import dsp_pkg::*;
();

   localparam int NUM_SLOTS = 8;
   localparam int NUM_SRC   = NUM_SLOTS + 6;   // slots, 2 asg, 2 adc, 2 dac
   localparam int NUM_SNK   = NUM_SLOTS + 4;   // slots, 2 scope, 2 pwm
   localparam int NUM_MIX   = NUM_SLOTS + 2;   // slots and generators
   localparam int DAC_MAX   = 2**(DATA_W-1) - 1;
   localparam int DAC_MIN   = -(2**(DATA_W-1));
   localparam int DRV_DLY   = 10;              // ns past the rising edge
   localparam int ACK_WAIT  = 20;              // cycles

   logic                        clk_i, rstn_i;
   logic [DATA_W-1:0]           adc_a_i, adc_b_i, asg1_i, asg2_i;
   logic [NUM_SLOTS*DATA_W-1:0] slot_dat_i, slot_dat_o;
   logic [NUM_SLOTS-1:0]        sync_o;
   logic [DATA_W-1:0]           scope1_o, scope2_o, pwm0_o, pwm1_o, dac_a_o, dac_b_o;
   logic [31:0]                 sys_addr_i, sys_wdata_i, sys_rdata_o;
   logic                        sys_wen_i, sys_ren_i, sys_err_o, sys_ack_o;

   int tests = 0, checks = 0, errors = 0, test_errs = 0;
   int                sel_tab [NUM_SNK];       // routing as programmed
   out_mode_e         mode_tab [NUM_MIX];
   logic [DATA_W-1:0] dac_exp [2];             // modelled dac outputs

   dsp_router #(.NUM_SLOTS(NUM_SLOTS)) dut_i (
      .clk_i, .rstn_i, .adc_a_i, .adc_b_i, .asg1_i, .asg2_i, .slot_dat_i, .slot_dat_o,
      .sync_o, .scope1_o, .scope2_o, .pwm0_o, .pwm1_o, .dac_a_o, .dac_b_o,
      .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i, .sys_rdata_o, .sys_err_o,
      .sys_ack_o
   );

   bind dsp_router dsp_router_props props_i (
      .clk_i (clk_i), .rstn_i (rstn_i), .wen_i (sys_wen_i), .ren_i (sys_ren_i),
      .ack_i (sys_ack_o), .err_i (sys_err_o), .dac_a_i (dac_a_o), .dac_b_i (dac_b_o),
      .sat_i (sat_flags)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;              // 100 ns period
   end

   function automatic logic [DATA_W-1:0] rand_sample(int span);
      if (span == 0) return DATA_W'($urandom); // full scale
      return DATA_W'(int'($urandom_range(0, 2 * span)) - span);
   endfunction

   // source value by number with the dacs taken from the model
   function automatic logic [DATA_W-1:0] src_value(int n);
      if (n < NUM_SLOTS) return slot_dat_i[n*DATA_W +: DATA_W];
      case (n - NUM_SLOTS)
         SRC_ASG1_OFS: return asg1_i;
         SRC_ASG2_OFS: return asg2_i;
         SRC_ADC1_OFS: return adc_a_i;
         SRC_ADC2_OFS: return adc_b_i;
         SRC_DAC1_OFS: return dac_exp[0];
         SRC_DAC2_OFS: return dac_exp[1];
         default:      return '0;              // none or spare number
      endcase
   endfunction

   function automatic logic [DATA_W-1:0] sink_value(int s);
      if (s < NUM_SLOTS) return slot_dat_o[s*DATA_W +: DATA_W];
      if (s == NUM_SLOTS + SNK_SCOPE1_OFS) return scope1_o;
      if (s == NUM_SLOTS + SNK_SCOPE2_OFS) return scope2_o;
      if (s == NUM_SLOTS + SNK_PWM0_OFS) return pwm0_o;
      return pwm1_o;
   endfunction

   function automatic int default_sel(int s);
      if (s < NUM_SLOTS || s == NUM_SLOTS + SNK_SCOPE1_OFS) return NUM_SLOTS + SRC_ADC1_OFS;
      if (s == NUM_SLOTS + SNK_SCOPE2_OFS) return NUM_SLOTS + SRC_ADC2_OFS;
      return SRC_NONE;                         // pwm sinks
   endfunction

   // signed sum of the sources enabled on channel ch
   function automatic int mix_sum(int ch);
      int acc;
      acc = 0;
      for (int m = 0; m < NUM_MIX; m++) begin
         if (mode_tab[m] == OUT_BOTH || (ch == 0 && mode_tab[m] == OUT_DAC1) ||
             (ch == 1 && mode_tab[m] == OUT_DAC2)) begin
            acc += int'($signed(src_value(m)));  // mix index equals source number
         end
      end
      return acc;
   endfunction

   function automatic logic [DATA_W-1:0] clamp(int v);
      if (v > DAC_MAX) return DATA_W'(DAC_MAX);
      if (v < DAC_MIN) return DATA_W'(DAC_MIN);
      return DATA_W'(v);
   endfunction

   function automatic logic [1:0] sat_expected();
      logic [1:0] f;
      for (int c = 0; c < 2; c++) begin
         f[c] = (mix_sum(c) > DAC_MAX) || (mix_sum(c) < DAC_MIN);
      end
      return f;
   endfunction

   task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
         test_errs++;
      end
   endtask

   // one access entered and left at the drive point after an edge
   task automatic bus_cycle(input logic wr, input int unit, input logic [15:0] ofs,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int cnt;
      cnt         = 0;
      sys_addr_i  = {12'h0, 4'(unit), ofs};
      sys_wdata_i = wdata;
      sys_wen_i   = wr;
      sys_ren_i   = !wr;
      @(posedge clk_i);
      #DRV_DLY;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      while (!sys_ack_o && cnt < ACK_WAIT) begin
         @(posedge clk_i);
         #DRV_DLY;
         cnt++;
      end
      if (!sys_ack_o) begin
         $display("bus acknowledge never arrived at %0t for unit %0d", $time, unit);
         test_errs++;
      end
      rdata = sys_rdata_o;
   endtask

   task automatic bus_write(input int unit, input logic [15:0] ofs, input logic [31:0] wdata);
      logic [31:0] ignored;
      bus_cycle(1'b1, unit, ofs, wdata, ignored);
   endtask

   task automatic expect_reg(input int unit, input logic [15:0] ofs, input logic [31:0] exp,
                             input string what);
      logic [31:0] rd;
      bus_cycle(1'b0, unit, ofs, 32'h0, rd);
      expect_eq($sformatf("%s unit %0d", what, unit), rd, exp);
   endtask

   task automatic drive_inputs(input int span);
      adc_a_i = rand_sample(span);
      adc_b_i = rand_sample(span);
      asg1_i  = rand_sample(span);
      asg2_i  = rand_sample(span);
      for (int k = 0; k < NUM_SLOTS; k++) begin
         slot_dat_i[k*DATA_W +: DATA_W] = rand_sample(span);
      end
   endtask

   task automatic set_mix_value(input int m, input logic [DATA_W-1:0] v);
      if (m < NUM_SLOTS) slot_dat_i[m*DATA_W +: DATA_W] = v;
      else if (m == NUM_SLOTS + SRC_ASG1_OFS) asg1_i = v;
      else asg2_i = v;
   endtask

   task automatic set_mode(input int m, input out_mode_e md);
      mode_tab[m] = md;
      bus_write(m, REG_OUTPUT_SEL, 32'(md));
   endtask

   // wait out the 5 cycle mixer latency and refresh the dac model
   task automatic settle_mixer();
      repeat (5) @(posedge clk_i);
      #DRV_DLY;
      dac_exp[0] = clamp(mix_sum(0));
      dac_exp[1] = clamp(mix_sum(1));
   endtask

   task automatic check_dacs(input string what);
      expect_eq({what, " dac a"}, 32'(dac_a_o), 32'(dac_exp[0]));
      expect_eq({what, " dac b"}, 32'(dac_b_o), 32'(dac_exp[1]));
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s finished with %0d errors", tests, name, test_errs);
      errors   += test_errs;
      test_errs = 0;
   endtask

   initial begin
      logic [31:0] sync_val;
      void'($urandom(65965));
      rstn_i      = 1'b0;
      sys_addr_i  = '0;
      sys_wdata_i = '0;
      sys_wen_i   = 1'b0;
      sys_ren_i   = 1'b0;
      dac_exp[0]  = '0;
      dac_exp[1]  = '0;
      for (int m = 0; m < NUM_MIX; m++) mode_tab[m] = OUT_OFF;
      drive_inputs(0);
      repeat (16) @(posedge clk_i);
      #DRV_DLY;
      rstn_i = 1'b1;

      for (int s = 0; s < NUM_SNK; s++) expect_reg(s, REG_INPUT_SEL, default_sel(s), "sel");
      for (int m = 0; m < NUM_MIX; m++) expect_reg(m, REG_OUTPUT_SEL, OUT_OFF, "mode");
      expect_reg(0, REG_SYNC, 2**NUM_SLOTS - 1, "sync");
      expect_eq("pwm0 idle", pwm0_o, 0);
      expect_eq("pwm1 idle", pwm1_o, 0);
      check_dacs("reset");
      end_test("reset defaults");

      for (int s = 0; s < NUM_SNK; s++) begin
         sel_tab[s] = (s == NUM_SNK - 1) ? SRC_NONE : $urandom_range(0, 15); // spares too
         bus_write(s, REG_INPUT_SEL, sel_tab[s]);
      end
      repeat (4) begin
         drive_inputs(0);
         #1;                                    // crossbar is combinational
         for (int s = 0; s < NUM_SNK; s++) begin
            expect_eq($sformatf("sink %0d", s), sink_value(s), src_value(sel_tab[s]));
         end
         @(posedge clk_i);
         #DRV_DLY;
      end
      for (int n = 0; n < NUM_SRC; n++) expect_reg(n, REG_SIGNAL, src_value(n), "signal");
      end_test("crossbar routing");

      for (int r = 0; r < 2; r++) begin
         drive_inputs(800);                    // ten sources stay below the clamp
         for (int m = 0; m < NUM_MIX; m++) begin
            set_mode(m, (m < 3) ? out_mode_e'(m + 1) : out_mode_e'($urandom_range(0, 3)));
         end
         settle_mixer();
         check_dacs("mix");
      end
      end_test("mixing");

      for (int m = 0; m < NUM_MIX; m++) set_mode(m, (m < NUM_MIX / 2) ? OUT_DAC1 : OUT_DAC2);
      for (int ph = 0; ph < 3; ph++) begin    // both clamped, dac a only, none
         for (int m = 0; m < NUM_MIX; m++) begin
            if (m < NUM_MIX / 2) set_mix_value(m, ph < 2 ? DATA_W'(8000) : rand_sample(100));
            else set_mix_value(m, ph < 1 ? DATA_W'(-8000) : rand_sample(100));
         end
         settle_mixer();
         check_dacs("saturation");
         if (ph == 0) expect_eq("clamp high", dac_a_o, DATA_W'(DAC_MAX));
         expect_reg(0, REG_SAT_FLAGS, sat_expected(), "sat flags");
      end
      end_test("saturation");

      bus_write(0, REG_INPUT_SEL, NUM_SLOTS + SRC_DAC1_OFS);
      for (int r = 0; r < 3; r++) begin
         drive_inputs(800);
         settle_mixer();
         expect_eq("slot 0 feedback", slot_dat_o[DATA_W-1:0], dac_exp[0]);
      end
      sync_val = $urandom;                     // upper bits must be dropped
      bus_write(0, REG_SYNC, sync_val);
      expect_eq("sync output", sync_o, sync_val[NUM_SLOTS-1:0]);
      expect_reg(0, REG_SYNC, sync_val[NUM_SLOTS-1:0], "sync readback");
      expect_reg(0, 16'h0014, 0, "unmapped offset");
      expect_reg(NUM_SNK, REG_INPUT_SEL, 0, "unit past table");
      end_test("feedback and sync");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/dsp_router_props.sv */
// *********************************************************************
// dsp router properties
// bus acknowledge timing, error line and dac range
// *********************************************************************
`timescale 1ns/10ps
`default_nettype none

module dsp_router_props
   import dsp_pkg::*;
(
   input logic              clk_i,
   input logic              rstn_i,
   input logic              wen_i,
   input logic              ren_i,
   input logic              ack_i,
   input logic              err_i,
   input logic [DATA_W-1:0] dac_a_i,
   input logic [DATA_W-1:0] dac_b_i,
   input logic [1:0]        sat_i     // bit0 dac a
);

   localparam int DAC_MAX = 2**(DATA_W-1) - 1;
   localparam int DAC_MIN = -(2**(DATA_W-1));

   // every access acked on the following edge
   ack_after_enable: assert property (
      @(posedge clk_i) disable iff (!rstn_i) (wen_i || ren_i) |=> ack_i
   ) else $error("bus acknowledge missing one cycle after an enable");

   ack_needs_enable: assert property (
      @(posedge clk_i) disable iff (!rstn_i) !(wen_i || ren_i) |=> !ack_i
   ) else $error("bus acknowledge without a preceding enable");

   err_stays_low: assert property (
      @(posedge clk_i) !err_i
   ) else $error("bus error line went high");

   // known, and pinned to a range limit while clamping
   dac_a_in_range: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
         !$isunknown(dac_a_i) &&
         (!sat_i[0] || int'($signed(dac_a_i)) inside {DAC_MIN, DAC_MAX})
   ) else $error("dac a output unknown or off its range limit while saturated");

   dac_b_in_range: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
         !$isunknown(dac_b_i) &&
         (!sat_i[1] || int'($signed(dac_b_i)) inside {DAC_MIN, DAC_MAX})
   ) else $error("dac b output unknown or off its range limit while saturated");

endmodule

`default_nettype wire

/* source/dsp_router.sv */
// *********************************************************************
// dsp signal router
// bus programmed crossbar between slots, converters, scope and pwm,
// plus the summing dac mixer
// *********************************************************************
`timescale 1ns/10ps
`default_nettype none

module dsp_router
   import dsp_pkg::*;
#(
   parameter int NUM_SLOTS = 8               // even, 2 to 8
) (
   input  logic                        clk_i,
   input  logic                        rstn_i,
   // converters and generators
   input  logic [DATA_W-1:0]           adc_a_i,
   input  logic [DATA_W-1:0]           adc_b_i,
   input  logic [DATA_W-1:0]           asg1_i,
   input  logic [DATA_W-1:0]           asg2_i,
   // processing slots, results in and selected inputs out
   input  logic [NUM_SLOTS*DATA_W-1:0] slot_dat_i,
   output logic [NUM_SLOTS*DATA_W-1:0] slot_dat_o,
   output logic [NUM_SLOTS-1:0]        sync_o,
   // taps
   output logic [DATA_W-1:0]           scope1_o,
   output logic [DATA_W-1:0]           scope2_o,
   output logic [DATA_W-1:0]           pwm0_o,
   output logic [DATA_W-1:0]           pwm1_o,
   output logic [DATA_W-1:0]           dac_a_o,
   output logic [DATA_W-1:0]           dac_b_o,
   // register bus
   input  logic [31:0]                 sys_addr_i,
   input  logic [31:0]                 sys_wdata_i,
   input  logic                        sys_wen_i,
   input  logic                        sys_ren_i,
   output logic [31:0]                 sys_rdata_o,
   output logic                        sys_err_o,
   output logic                        sys_ack_o
);

   logic [num_snk(NUM_SLOTS)*SEL_W-1:0]  in_sel;
   logic [num_mix(NUM_SLOTS)*2-1:0]      out_mode;
   logic [num_src(NUM_SLOTS)*DATA_W-1:0] src_dat;   // for REG_SIGNAL reads
   logic [num_mix(NUM_SLOTS)*DATA_W-1:0] mix_dat;
   logic [1:0]                           sat_flags;

   // mixing order matches the source numbering, generators after the slots
   assign mix_dat = {asg2_i, asg1_i, slot_dat_i};

   dsp_route_regs #(
      .NUM_SLOTS   (NUM_SLOTS)
   ) i_regs (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .src_dat_i   (src_dat),
      .sat_flags_i (sat_flags),
      .in_sel_o    (in_sel),
      .out_mode_o  (out_mode),
      .sync_o      (sync_o),
      .sys_rdata_o (sys_rdata_o),
      .sys_err_o   (sys_err_o),
      .sys_ack_o   (sys_ack_o)
   );

   dsp_input_mux #(
      .NUM_SLOTS  (NUM_SLOTS)
   ) i_mux (
      .slot_dat_i (slot_dat_i),
      .asg1_i     (asg1_i),
      .asg2_i     (asg2_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .dac_a_i    (dac_a_o),               // dac feedback
      .dac_b_i    (dac_b_o),
      .in_sel_i   (in_sel),
      .src_dat_o  (src_dat),
      .slot_dat_o (slot_dat_o),
      .scope1_o   (scope1_o),
      .scope2_o   (scope2_o),
      .pwm0_o     (pwm0_o),
      .pwm1_o     (pwm1_o)
   );

   dsp_dac_mixer #(
      .NUM_SLOTS   (NUM_SLOTS)
   ) i_mixer (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .mix_dat_i   (mix_dat),
      .out_mode_i  (out_mode),
      .dac_a_o     (dac_a_o),
      .dac_b_o     (dac_b_o),
      .sat_flags_o (sat_flags)
   );

endmodule

`default_nettype wire

/* source/dsp_dac_mixer.sv */
// *********************************************************************
// dac output mixer
// two pipelined adder trees with saturation to the dac width
// *********************************************************************
`timescale 1ns/10ps
`default_nettype none

module dsp_dac_mixer
   import dsp_pkg::*;
#(
   parameter int NUM_SLOTS = 8
) (
   input  logic                                 clk_i,
   input  logic                                 rstn_i,
   input  logic [num_mix(NUM_SLOTS)*DATA_W-1:0] mix_dat_i,   // slots then generators
   input  logic [num_mix(NUM_SLOTS)*2-1:0]      out_mode_i,
   output logic [DATA_W-1:0]                    dac_a_o,
   output logic [DATA_W-1:0]                    dac_b_o,
   output logic [1:0]                           sat_flags_o  // bit0 dac a
);

   localparam int NUM_MIX = num_mix(NUM_SLOTS);

   localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(2**(DATA_W-1) - 1);
   localparam logic signed [SUM_W-1:0] SAT_MIN = SUM_W'(-(2**(DATA_W-1)));

   // index 0 is dac a, 1 is dac b throughout
   logic signed [SUM_W-1:0] leaf   [2][MIX_CHANNELS];
   logic signed [SUM_W-1:0] pair_q [2][MIX_CHANNELS/2];  // stage 1
   logic signed [SUM_W-1:0] lvl1_q [2][MIX_CHANNELS/4];  // stage 2
   logic signed [SUM_W-1:0] lvl2_q [2][MIX_CHANNELS/8];  // stage 3
   logic signed [SUM_W-1:0] lvl3_q [2];                  // stage 4
   logic signed [SUM_W-1:0] sum_q  [2];                  // stage 5
   logic [DATA_W-1:0]       dac    [2];

   // does a source with this mode feed channel ch
   function automatic logic mode_hits(out_mode_e mode, int ch);
      case (mode)
         OUT_BOTH: return 1'b1;
         OUT_DAC1: return (ch == 0);
         OUT_DAC2: return (ch == 1);
         default:  return 1'b0;
      endcase
   endfunction

   for (genvar m = 0; m < MIX_CHANNELS; m++) begin : g_leaf
      if (m < NUM_MIX) begin : g_src
         out_mode_e               mode;
         logic [DATA_W-1:0]       smp;
         logic signed [SUM_W-1:0] ext;
         assign mode = out_mode_e'(out_mode_i[2*m +: 2]);
         assign smp  = mix_dat_i[m*DATA_W +: DATA_W];
         assign ext  = {{(SUM_W-DATA_W){smp[DATA_W-1]}}, smp}; // sign extend
         for (genvar c = 0; c < 2; c++) begin : g_ch
            assign leaf[c][m] = mode_hits(mode, c) ? ext : '0;
         end
      end else begin : g_pad
         assign leaf[0][m] = '0;             // spare leaves
         assign leaf[1][m] = '0;
      end
   end

   // tree stages, flushed to zero while modes are off in reset
   always_ff @(posedge clk_i) begin
      for (int c = 0; c < 2; c++) begin
         for (int i = 0; i < MIX_CHANNELS/2; i++) begin
            pair_q[c][i] <= leaf[c][2*i] + leaf[c][2*i+1];
         end
         for (int i = 0; i < MIX_CHANNELS/4; i++) begin
            lvl1_q[c][i] <= pair_q[c][2*i] + pair_q[c][2*i+1];
         end
         for (int i = 0; i < MIX_CHANNELS/8; i++) begin
            lvl2_q[c][i] <= lvl1_q[c][2*i] + lvl1_q[c][2*i+1];
         end
         lvl3_q[c] <= lvl2_q[c][0] + lvl2_q[c][1];
      end
   end

   // output register, dacs at zero in reset
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sum_q[0] <= '0;
         sum_q[1] <= '0;
      end else begin
         sum_q[0] <= lvl3_q[0];
         sum_q[1] <= lvl3_q[1];
      end
   end

   // clamp to signed dac range, flag follows the clamp
   always_comb begin
      for (int c = 0; c < 2; c++) begin
         if (sum_q[c] > SAT_MAX) begin
            dac[c]         = SAT_MAX[DATA_W-1:0];
            sat_flags_o[c] = 1'b1;
         end else if (sum_q[c] < SAT_MIN) begin
            dac[c]         = SAT_MIN[DATA_W-1:0];
            sat_flags_o[c] = 1'b1;
         end else begin
            dac[c]         = sum_q[c][DATA_W-1:0];
            sat_flags_o[c] = 1'b0;
         end
      end
   end

   assign dac_a_o = dac[0];
   assign dac_b_o = dac[1];

endmodule

`default_nettype wire

/* source/dsp_input_mux.sv */
// *********************************************************************
// input crossbar
// every sink picks one numbered source, unused numbers read as zero
// *********************************************************************
`timescale 1ns/10ps
`default_nettype none

module dsp_input_mux
   import dsp_pkg::*;
#(
   parameter int NUM_SLOTS = 8
) (
   input  logic [NUM_SLOTS*DATA_W-1:0]          slot_dat_i,  // slot results
   input  logic [DATA_W-1:0]                    asg1_i,
   input  logic [DATA_W-1:0]                    asg2_i,
   input  logic [DATA_W-1:0]                    adc_a_i,
   input  logic [DATA_W-1:0]                    adc_b_i,
   input  logic [DATA_W-1:0]                    dac_a_i,     // registered, no loop
   input  logic [DATA_W-1:0]                    dac_b_i,
   input  logic [num_snk(NUM_SLOTS)*SEL_W-1:0]  in_sel_i,
   output logic [num_src(NUM_SLOTS)*DATA_W-1:0] src_dat_o,
   output logic [NUM_SLOTS*DATA_W-1:0]          slot_dat_o,  // slot inputs
   output logic [DATA_W-1:0]                    scope1_o,
   output logic [DATA_W-1:0]                    scope2_o,
   output logic [DATA_W-1:0]                    pwm0_o,
   output logic [DATA_W-1:0]                    pwm1_o
);

   localparam int NUM_SRC = num_src(NUM_SLOTS);
   localparam int NUM_SNK = num_snk(NUM_SLOTS);

   // full 16 entry table so any select value is a legal index
   logic [DATA_W-1:0] src_tab [2**SEL_W];
   logic [DATA_W-1:0] snk_dat [NUM_SNK];

   always_comb begin
      for (int k = 0; k < 2**SEL_W; k++) begin
         src_tab[k] = '0;                      // SRC_NONE and spare numbers
      end
      for (int k = 0; k < NUM_SLOTS; k++) begin
         src_tab[k] = slot_dat_i[k*DATA_W +: DATA_W];
      end
      src_tab[NUM_SLOTS + SRC_ASG1_OFS] = asg1_i;
      src_tab[NUM_SLOTS + SRC_ASG2_OFS] = asg2_i;
      src_tab[NUM_SLOTS + SRC_ADC1_OFS] = adc_a_i;
      src_tab[NUM_SLOTS + SRC_ADC2_OFS] = adc_b_i;
      src_tab[NUM_SLOTS + SRC_DAC1_OFS] = dac_a_i;
      src_tab[NUM_SLOTS + SRC_DAC2_OFS] = dac_b_i;
   end

   for (genvar k = 0; k < NUM_SRC; k++) begin : g_src
      assign src_dat_o[k*DATA_W +: DATA_W] = src_tab[k]; // for bus readback
   end

   for (genvar s = 0; s < NUM_SNK; s++) begin : g_snk
      assign snk_dat[s] = src_tab[in_sel_i[s*SEL_W +: SEL_W]];
   end

   for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_slot
      assign slot_dat_o[k*DATA_W +: DATA_W] = snk_dat[k];
   end

   // scope and pwm taps sit right after the slots
   assign scope1_o = snk_dat[NUM_SLOTS + SNK_SCOPE1_OFS];
   assign scope2_o = snk_dat[NUM_SLOTS + SNK_SCOPE2_OFS];
   assign pwm0_o   = snk_dat[NUM_SLOTS + SNK_PWM0_OFS];
   assign pwm1_o   = snk_dat[NUM_SLOTS + SNK_PWM1_OFS];

endmodule

`default_nettype wire

/* source/dsp_route_regs.sv */
// *********************************************************************
// routing register bank
// crossbar and dac mode tables, sync mask and registered bus read
// *********************************************************************
`timescale 1ns/10ps
`default_nettype none

module dsp_route_regs
   import dsp_pkg::*;
#(
   parameter int NUM_SLOTS = 8
) (
   input  logic                                 clk_i,
   input  logic                                 rstn_i,
   input  logic [31:0]                          sys_addr_i,
   input  logic [31:0]                          sys_wdata_i,
   input  logic                                 sys_wen_i,
   input  logic                                 sys_ren_i,
   input  logic [num_src(NUM_SLOTS)*DATA_W-1:0] src_dat_i,
   input  logic [1:0]                           sat_flags_i,
   output logic [num_snk(NUM_SLOTS)*SEL_W-1:0]  in_sel_o,
   output logic [num_mix(NUM_SLOTS)*2-1:0]      out_mode_o,
   output logic [NUM_SLOTS-1:0]                 sync_o,
   output logic [31:0]                          sys_rdata_o,
   output logic                                 sys_err_o,
   output logic                                 sys_ack_o
);

   localparam int NUM_SRC = num_src(NUM_SLOTS);
   localparam int NUM_SNK = num_snk(NUM_SLOTS);
   localparam int NUM_MIX = num_mix(NUM_SLOTS);

   logic [SEL_W-1:0]   in_sel_q [NUM_SNK];    // source number per sink
   out_mode_e          out_mode_q [NUM_MIX];  // dac mode per mixing source
   logic [NUM_SLOTS-1:0] sync_q;

   logic [3:0]         unit;                  // addressed slot/sink/source
   reg_offset_e        reg_ofs;
   logic [31:0]        rdata_d;

   assign unit    = sys_addr_i[19:16];
   assign reg_ofs = reg_offset_e'(sys_addr_i[15:0]);

   // table writes and ack, reset gives the default routing
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < NUM_SLOTS; k++) begin
            in_sel_q[k] <= SEL_W'(NUM_SLOTS + SRC_ADC1_OFS); // slots listen to adc1
         end
         in_sel_q[NUM_SLOTS + SNK_SCOPE1_OFS] <= SEL_W'(NUM_SLOTS + SRC_ADC1_OFS);
         in_sel_q[NUM_SLOTS + SNK_SCOPE2_OFS] <= SEL_W'(NUM_SLOTS + SRC_ADC2_OFS);
         in_sel_q[NUM_SLOTS + SNK_PWM0_OFS]   <= SRC_NONE;   // pwm idle
         in_sel_q[NUM_SLOTS + SNK_PWM1_OFS]   <= SRC_NONE;
         for (int m = 0; m < NUM_MIX; m++) begin
            out_mode_q[m] <= OUT_OFF;          // nothing reaches the dacs
         end
         sync_q    <= '1;                      // all slots running
         sys_ack_o <= 1'b0;
      end else begin
         sys_ack_o <= sys_wen_i | sys_ren_i;   // one cycle, every offset
         if (sys_wen_i) begin
            case (reg_ofs)
               REG_INPUT_SEL: begin
                  if (unit < NUM_SNK) in_sel_q[unit] <= sys_wdata_i[SEL_W-1:0];
               end
               REG_OUTPUT_SEL: begin
                  if (unit < NUM_MIX) out_mode_q[unit] <= out_mode_e'(sys_wdata_i[1:0]);
               end
               REG_SYNC: sync_q <= sys_wdata_i[NUM_SLOTS-1:0];
               default: ;                      // read only or unmapped
            endcase
         end
      end
   end

   // read word, zero for unmapped offsets and units past a table
   always_comb begin
      rdata_d = '0;
      case (reg_ofs)
         REG_INPUT_SEL: begin
            if (unit < NUM_SNK) rdata_d = 32'(in_sel_q[unit]);
         end
         REG_OUTPUT_SEL: begin
            if (unit < NUM_MIX) rdata_d = 32'(out_mode_q[unit]);
         end
         REG_SAT_FLAGS: rdata_d = 32'(sat_flags_i);   // bit0 dac1, bit1 dac2
         REG_SYNC:      rdata_d = 32'(sync_q);
         REG_SIGNAL: begin
            // raw sample bits, no sign extension
            if (unit < NUM_SRC) rdata_d = 32'(src_dat_i[unit*DATA_W +: DATA_W]);
         end
         default: rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      sys_rdata_o <= rdata_d;                  // valid alongside ack
   end

   assign sys_err_o = 1'b0;                    // router never flags errors

   // flatten tables for the crossbar and mixer
   for (genvar s = 0; s < NUM_SNK; s++) begin : g_sel_out
      assign in_sel_o[s*SEL_W +: SEL_W] = in_sel_q[s];
   end

   for (genvar m = 0; m < NUM_MIX; m++) begin : g_mode_out
      assign out_mode_o[2*m +: 2] = out_mode_q[m];
   end

   assign sync_o = sync_q;

endmodule

`default_nettype wire

/* source/dsp_pkg.sv */
// *********************************************************************
// dsp router package
// sample widths, source/sink numbering and the routing register map
// *********************************************************************
`default_nettype none

package dsp_pkg;

   localparam int DATA_W = 14;              // adc/dac sample width
   localparam int SEL_W  = 4;               // source number width

   localparam logic [SEL_W-1:0] SRC_NONE = SEL_W'(15); // no source, reads as zero

   // source numbers past the slots
   localparam int SRC_ASG1_OFS = 0;
   localparam int SRC_ASG2_OFS = 1;
   localparam int SRC_ADC1_OFS = 2;
   localparam int SRC_ADC2_OFS = 3;
   localparam int SRC_DAC1_OFS = 4;         // dac outputs fed back
   localparam int SRC_DAC2_OFS = 5;

   // sink numbers past the slots
   localparam int SNK_SCOPE1_OFS = 0;
   localparam int SNK_SCOPE2_OFS = 1;
   localparam int SNK_PWM0_OFS   = 2;
   localparam int SNK_PWM1_OFS   = 3;

   localparam int SUM_W        = DATA_W + SEL_W; // headroom for 16 summed samples
   localparam int MIX_CHANNELS = 16;             // adder tree leaves

   typedef enum logic [15:0] {
      REG_INPUT_SEL  = 16'h0000,            // crossbar entry of a sink
      REG_OUTPUT_SEL = 16'h0004,            // dac mode of a mixing source
      REG_SAT_FLAGS  = 16'h0008,
      REG_SYNC       = 16'h000C,
      REG_SIGNAL     = 16'h0010             // live value of a source
   } reg_offset_e;

   typedef enum logic [1:0] {
      OUT_OFF  = 2'd0,
      OUT_DAC1 = 2'd1,
      OUT_DAC2 = 2'd2,
      OUT_BOTH = 2'd3
   } out_mode_e;

   // table sizes derived from the slot count
   function automatic int num_src(int slots);
      return slots + SRC_DAC2_OFS + 1;
   endfunction

   function automatic int num_snk(int slots);
      return slots + SNK_PWM1_OFS + 1;
   endfunction

   function automatic int num_mix(int slots);
      return slots + SRC_ASG2_OFS + 1;       // slots plus both generators
   endfunction

endpackage

`default_nettype wire
